// File: sim.f
+incdir+verilog
verilog/pcie_rx_pkg.sv
verilog/rx_hdr_decode.sv
verilog/rx_target_fsm.sv
verilog/usr_reg_port.sv
verilog/pcie_rx.sv
sim/tb_pcie_rx.sv

// File: sim/tb_pcie_rx.sv
/* Random-stimulus testbench for the receive engine with reference model,
   compare tasks, completion responder and run limit */
`timescale 1ns/10ps
`include "pcie_rx_params.svh"

module tb_pcie_rx;

  import pcie_rx_pkg::*;

  localparam int N_PKT       = 60;
  localparam int TIMEOUT_CYC = N_PKT * 40 + 100;   // 40 cycles per packet plus reset margin

  logic                  clk;
  logic                  rst_n;
  trn_rx_t               trn_rx;
  logic [`TRN_BAR_W-1:0] bar_hit_n;
  logic                  rdst_rdy_n;
  usr_reg_t              usr_reg;
  logic [29:0]           req_addr;
  req_desc_t             req_desc;
  logic                  req_compl;
  logic                  compl_done;

  logic [31:0] rng_state;
  int          cycle_cnt;
  int          n_checks;
  int          n_errors;
  req_desc_t   model_desc;     // Last descriptor loaded at SOF
  logic [29:0] model_addr;     // Last address taken at EOF

  pcie_rx u_pcie_rx (
    .clk              (clk),
    .rst_n            (rst_n),
    .trn_rx_i         (trn_rx),
    .trn_rbar_hit_n_i (bar_hit_n),
    .trn_rdst_rdy_n_o (rdst_rdy_n),
    .usr_reg_o        (usr_reg),
    .req_addr_o       (req_addr),
    .req_desc_o       (req_desc),
    .req_compl_o      (req_compl),
    .compl_done_i     (compl_done)
  );

  always
  begin
    #4 clk = ~clk;             // 8 ns period
  end

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("ERROR: run still busy after %0d cycles, DUT seems stalled", TIMEOUT_CYC);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //------------------------------------------------------------
  // Random numbers and reference rules
  //------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Byte 0 of the link arrives in the top lane
  function automatic logic [31:0] byte_swap(input logic [31:0] d);
    logic [31:0] s;
    for (int i = 0; i < 4; i++)
      s[8*i +: 8] = d[8*(3-i) +: 8];   // Byte i from lane 3-i
    return s;
  endfunction

  function automatic logic [6:0] fmt_type_of(input tlp_kind_e k);
    case (k)
      TLP_MWR  : return `FMT_TYPE_MWR32;
      TLP_MRD  : return `FMT_TYPE_MRD32;
      TLP_IOWR : return `FMT_TYPE_IOWR32;
      default  : return `FMT_TYPE_IORD32;
    endcase
  endfunction

  function automatic string kind_text(input tlp_kind_e k);
    case (k)
      TLP_MWR  : return "MWr";
      TLP_MRD  : return "MRd";
      TLP_IOWR : return "IOWr";
      default  : return "IORd";
    endcase
  endfunction

  //------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks = n_checks + 1;
    if (got !== exp)
    begin
      n_errors = n_errors + 1;
      $display("FAIL %s at %0t: exp %h got %h", name, $time, exp, got);
    end
  endtask

  task automatic check_usr_reg(input usr_reg_t got, input usr_reg_t exp);
    n_checks = n_checks + 1;
    if (got !== exp)
    begin
      n_errors = n_errors + 1;
      $display("FAIL usr_reg_o at %0t: exp %h got %h", $time, exp, got);
    end
  endtask

  task automatic check_desc(input req_desc_t got, input req_desc_t exp);
    n_checks = n_checks + 1;
    if (got !== exp)
    begin
      n_errors = n_errors + 1;
      $display("FAIL req_desc_o at %0t: exp %h got %h", $time, exp, got);
    end
  endtask

  task automatic check_addr(input logic [29:0] got, input logic [29:0] exp);
    n_checks = n_checks + 1;
    if (got !== exp)
    begin
      n_errors = n_errors + 1;
      $display("FAIL req_addr_o at %0t: exp %h got %h", $time, exp, got);
    end
  endtask

  //------------------------------------------------------------
  // Bus driving 1 ns after the rising edge
  //------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_beat(input logic [63:0] qw, input logic sof_n, input logic eof_n);
    int gaps;

    gaps = next_rand() % 3;
    repeat (gaps)
    begin
      trn_rx.src_rdy_n = 1'b1;          // Source gap with junk on the bus
      trn_rx.rd[63:32] = next_rand();
      trn_rx.rd[31:0]  = next_rand();
      next_cycle();
    end
    trn_rx.rd        = qw;
    trn_rx.sof_n     = sof_n;
    trn_rx.eof_n     = eof_n;
    trn_rx.src_rdy_n = 1'b0;
    while (rdst_rdy_n)
      next_cycle();
    next_cycle();                       // Edge that takes the beat
    trn_rx.sof_n     = 1'b1;
    trn_rx.eof_n     = 1'b1;
    trn_rx.src_rdy_n = 1'b1;
  endtask

  // Core drops the packet after SOF
  task automatic abort_packet();
    repeat (next_rand() % 3)
      next_cycle();
    trn_rx.src_dsc_n = 1'b0;
    next_cycle();
    trn_rx.src_dsc_n = 1'b1;
  endtask

  // TX engine side raises done 1 to 6 cycles after the request
  task automatic serve_completion(input usr_reg_t idle_reg);
    int delay;

    delay = 1 + next_rand() % 6;
    repeat (delay)
    begin
      next_cycle();
      check_usr_reg(usr_reg, idle_reg);   // No second strobe
      check_bit("req_compl_o", req_compl, 1'b1);
      check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, 1'b1);
    end
    compl_done = 1'b1;
    next_cycle();
    compl_done = 1'b0;
    check_usr_reg(usr_reg, idle_reg);
    check_bit("req_compl_o", req_compl, 1'b0);
    check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, 1'b0);
  endtask

  task automatic check_quiet(input int n);
    repeat (n)
    begin
      check_bit("usr_reg_o.wr", usr_reg.wr, 1'b0);
      check_bit("usr_reg_o.rd", usr_reg.rd, 1'b0);
      check_bit("req_compl_o", req_compl, 1'b0);
      check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, 1'b0);
      next_cycle();
    end
  endtask

  // Starts in the cycle after the EOF edge
  task automatic check_response(input tlp_kind_e kind, input usr_reg_t exp_reg);
    usr_reg_t idle_reg;

    idle_reg    = exp_reg;
    idle_reg.wr = 1'b0;
    idle_reg.rd = 1'b0;
    check_usr_reg(usr_reg, exp_reg);
    check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, 1'b1);
    check_bit("req_compl_o", req_compl, kind == TLP_IOWR);
    if (kind == TLP_IOWR)
      serve_completion(idle_reg);      // IOWr asks at once
    else
    begin
      next_cycle();
      check_usr_reg(usr_reg, idle_reg);
      check_bit("req_compl_o", req_compl, kind != TLP_MWR);
      check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, kind != TLP_MWR);
      if (kind != TLP_MWR)
        serve_completion(idle_reg);
    end
  endtask

  //------------------------------------------------------------
  // One random packet with its expected response
  //------------------------------------------------------------
  task automatic run_packet(input int idx);
    logic [31:0] r;
    tlp_kind_e   kind;
    int          fault;           // 0 good, 1 length, 2 type, 3 discontinue
    req_desc_t   hdr;
    logic [29:0] addr;
    logic [31:0] byte_addr;
    logic [31:0] data;
    logic        hit;
    usr_reg_t    exp_reg;
    int          err_start;
    string       note;

    err_start = n_errors;
    r = next_rand();
    case (r[1:0])
      2'd0    : kind = TLP_MWR;
      2'd1    : kind = TLP_MRD;
      2'd2    : kind = TLP_IOWR;
      default : kind = TLP_IORD;
    endcase
    case (r[7:4])
      4'd0, 4'd1 : fault = 1;
      4'd2       : fault = 2;
      4'd3, 4'd4 : fault = 3;
      default    : fault = 0;
    endcase
    bar_hit_n = '1;
    hit = (r[9:8] != 2'd3);       // User BAR three times in four
    if (r[9:8] == 2'd1)
      bar_hit_n[`BAR_USR1] = 1'b0;
    else if (hit)
      bar_hit_n[`BAR_USR0] = 1'b0;
    else
      bar_hit_n[2 + r[14:12] % 5] = 1'b0;

    r = next_rand();
    hdr.fmt_type = fmt_type_of(kind);
    hdr.tc       = r[2:0];
    hdr.td       = r[3];
    hdr.ep       = r[4];
    hdr.attr     = r[6:5];
    hdr.tag      = r[15:8];
    hdr.rid      = r[31:16];
    r = next_rand();
    hdr.be  = r[7:0];
    hdr.len = `HDR_LEN_ONE;
    if (fault == 1)
    begin
      hdr.len = r[17:8];
      if (hdr.len == `HDR_LEN_ONE)
        hdr.len = 10'd2;
    end
    if (fault == 2)
    begin
      case (r[19:18])
        2'd0    : hdr.fmt_type = 7'b01_00000;   // MRd with 4DW header
        2'd1    : hdr.fmt_type = 7'b11_00000;   // MWr with 4DW header
        2'd2    : hdr.fmt_type = 7'b10_01010;   // CplD
        default : hdr.fmt_type = 7'b00_00100;   // CfgRd0
      endcase
    end
    r    = next_rand();
    addr = r[29:0];
    data = next_rand();

    // DW0 with reserved bits zero followed by requester DW1
    send_beat({1'b0, hdr.fmt_type, 1'b0, hdr.tc, 4'h0, hdr.td, hdr.ep, hdr.attr, 2'b00,
               hdr.len, hdr.rid, hdr.tag, hdr.be}, 1'b0, 1'b1);
    if (fault != 1 && fault != 2 && kind != TLP_MWR)
      model_desc = hdr;           // Loaded at SOF even if aborted later
    if (fault == 3)
      abort_packet();
    else
      send_beat({addr, 2'b00, data}, 1'b1, 1'b0);

    if (fault != 0)
      check_quiet(3);
    else
    begin
      model_addr  = addr;
      byte_addr   = {addr, 2'b00};   // PCIe byte address of the DW
      exp_reg.adr = byte_addr[`USR_ADR_W-1:0];
      exp_reg.din = byte_swap(data);
      exp_reg.wr  = hit && (kind == TLP_MWR || kind == TLP_IOWR);
      exp_reg.rd  = hit && (kind == TLP_MRD || kind == TLP_IORD);
      check_response(kind, exp_reg);
    end
    check_desc(req_desc, model_desc);
    check_addr(req_addr, model_addr);

    note = hit ? "" : ", BAR miss";
    if (fault == 1)
      note = ", bad length";
    else if (fault == 2)
      note = ", bad type";
    else if (fault == 3)
      note = ", discontinued";
    $display("packet %0d %s%s: %s", idx, kind_text(kind), note,
             (n_errors == err_start) ? "ok" : "mismatch");
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial
  begin
    clk              = 1'b0;
    rst_n            = 1'b0;
    trn_rx.rd        = '0;
    trn_rx.sof_n     = 1'b1;
    trn_rx.eof_n     = 1'b1;
    trn_rx.src_rdy_n = 1'b1;
    trn_rx.src_dsc_n = 1'b1;
    bar_hit_n        = '1;
    compl_done       = 1'b0;
    rng_state        = 32'd28;
    cycle_cnt        = 0;
    n_checks         = 0;
    n_errors         = 0;
    model_desc       = '0;
    model_addr       = '0;

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    check_bit("usr_reg_o.wr", usr_reg.wr, 1'b0);
    check_bit("usr_reg_o.rd", usr_reg.rd, 1'b0);
    check_bit("req_compl_o", req_compl, 1'b0);
    check_bit("trn_rdst_rdy_n_o", rdst_rdy_n, 1'b0);
    check_desc(req_desc, model_desc);
    check_addr(req_addr, model_addr);
    $display("reset values: %s", (n_errors == 0) ? "ok" : "mismatch");

    for (int i = 0; i < N_PKT; i++)
      run_packet(i);

    $display("packets %0d, checks %0d, errors %0d", N_PKT, n_checks, n_errors);
    if (n_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog/pcie_rx.sv
/* PCIe receive engine top, target side: header decode,
   packet FSM and user register port */
`timescale 1ns/10ps
`include "pcie_rx_params.svh"

module pcie_rx (
  input  logic                             clk,
  input  logic                             rst_n,
  // Local-link receive from the core
  input  pcie_rx_pkg::trn_rx_t             trn_rx_i,
  input  logic [`TRN_BAR_W-1:0]            trn_rbar_hit_n_i,
  output logic                             trn_rdst_rdy_n_o,
  // User registers
  output pcie_rx_pkg::usr_reg_t            usr_reg_o,
  // Completion request to the TX engine
  output logic [`QW1_ADR_HI-`QW1_ADR_LO:0] req_addr_o,
  output pcie_rx_pkg::req_desc_t           req_desc_o,
  output logic                             req_compl_o,
  input  logic                             compl_done_i
);

  import pcie_rx_pkg::*;

  tlp_kind_e tlp_kind;   // Kind of the SOF qword on the bus
  logic      hdr_load;
  logic      qw1_take;
  logic      is_write;

  //------------------------------------------------------------
  // Header decode
  //------------------------------------------------------------
  rx_hdr_decode u_hdr_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .trn_rd_i   (trn_rx_i.rd),
    .hdr_load_i (hdr_load),
    .tlp_kind_o (tlp_kind),
    .req_desc_o (req_desc_o)
  );

  // Packet sequencing and completion handshake
  rx_target_fsm u_target_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .trn_rx_i         (trn_rx_i),
    .tlp_kind_i       (tlp_kind),
    .compl_done_i     (compl_done_i),
    .hdr_load_o       (hdr_load),
    .qw1_take_o       (qw1_take),
    .is_write_o       (is_write),
    .trn_rdst_rdy_n_o (trn_rdst_rdy_n_o),
    .req_compl_o      (req_compl_o)
  );

  //------------------------------------------------------------
  // User register access
  //------------------------------------------------------------
  usr_reg_port u_usr_reg_port (
    .clk              (clk),
    .rst_n            (rst_n),
    .trn_rd_i         (trn_rx_i.rd),
    .trn_rbar_hit_n_i (trn_rbar_hit_n_i),
    .qw1_take_i       (qw1_take),
    .is_write_i       (is_write),
    .usr_reg_o        (usr_reg_o),
    .req_addr_o       (req_addr_o)
  );

endmodule

// File: verilog/pcie_rx_params.svh
/* Bus widths, TLP header field positions, FMT/TYPE codes
   and user BAR indices for the receive engine */
`ifndef PCIE_RX_PARAMS_SVH
`define PCIE_RX_PARAMS_SVH

// Local-link core widths
`define TRN_DW     64       // Receive data
`define TRN_BAR_W  7        // BAR hit vector
`define USR_ADR_W  8        // User register address

//------------------------------------------------------------
// First header qword (DW0 in 63:32, DW1 in 31:0)
//------------------------------------------------------------
`define HDR_FT_HI    62     // FMT[1:0] + TYPE[4:0]
`define HDR_FT_LO    56
`define HDR_TC_HI    54     // Traffic class
`define HDR_TC_LO    52
`define HDR_TD_BIT   47     // Digest present
`define HDR_EP_BIT   46     // Poisoned
`define HDR_ATTR_HI  45
`define HDR_ATTR_LO  44
`define HDR_LEN_HI   41     // Payload length in DW
`define HDR_LEN_LO   32
`define HDR_RID_HI   31     // Requester ID
`define HDR_RID_LO   16
`define HDR_TAG_HI   15
`define HDR_TAG_LO   8
`define HDR_BE_HI    7      // Last/first DW byte enables
`define HDR_BE_LO    0

// Second qword: address DW then payload DW
`define QW1_ADR_HI   63     // ADDR[31:2]
`define QW1_ADR_LO   34
`define QW1_DAT_HI   31
`define QW1_DAT_LO   0

//------------------------------------------------------------
// FMT/TYPE codes, 3DW header only
//------------------------------------------------------------
`define FMT_TYPE_MWR32   7'b10_00000   // With data
`define FMT_TYPE_MRD32   7'b00_00000
`define FMT_TYPE_IOWR32  7'b10_00010   // With data
`define FMT_TYPE_IORD32  7'b00_00010

`define HDR_LEN_ONE  10'd1  // Only 1DW requests served

// User BARs in the hit vector
`define BAR_USR0  0
`define BAR_USR1  1

`endif

// File: verilog/pcie_rx_pkg.sv
/* Receive engine types: beat, completion descriptor,
   user register port, packet kind and FSM state */
`include "pcie_rx_params.svh"

package pcie_rx_pkg;

  //------------------------------------------------------------
  // One local-link receive beat, controls active low
  //------------------------------------------------------------
  typedef struct packed {
    logic [`TRN_DW-1:0] rd;         // Data qword
    logic               sof_n;      // Start of packet
    logic               eof_n;      // End of packet
    logic               src_rdy_n;  // Core presents valid data
    logic               src_dsc_n;  // Core aborts packet
  } trn_rx_t;

  // Fields the TX engine needs to build Cpl/CplD
  typedef struct packed {
    logic [6:0]  fmt_type;
    logic [2:0]  tc;                // Traffic class
    logic        td;                // Digest
    logic        ep;                // Poisoned
    logic [1:0]  attr;
    logic [9:0]  len;               // Always 1DW here
    logic [15:0] rid;               // Requester ID
    logic [7:0]  tag;
    logic [7:0]  be;                // Byte enables
  } req_desc_t;

  // User register side
  typedef struct packed {
    logic [`USR_ADR_W-1:0] adr;     // Byte address
    logic [31:0]           din;     // Write data, swapped
    logic                  wr;      // One-cycle write
    logic                  rd;      // One-cycle read
  } usr_reg_t;

  //------------------------------------------------------------
  // Packet classification
  //------------------------------------------------------------
  typedef enum logic [2:0] {
    TLP_NONE = 3'd0,                // Ignored packet
    TLP_MWR  = 3'd1,
    TLP_MRD  = 3'd2,
    TLP_IOWR = 3'd3,
    TLP_IORD = 3'd4
  } tlp_kind_e;

  // Target FSM states
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,             // Wait for SOF
    ST_QW1      = 3'd1,             // Wait for EOF qword
    ST_WR_END   = 3'd2,             // MWr tail, no completion
    ST_RD_WAIT1 = 3'd3,             // Read strobe cycle
    ST_CPL_WAIT = 3'd4              // Hold until TX done
  } rx_state_e;

endpackage

// File: verilog/rx_hdr_decode.sv
/* First header qword classifier and completion descriptor register */
`timescale 1ns/10ps
`include "pcie_rx_params.svh"

module rx_hdr_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`TRN_DW-1:0]     trn_rd_i,     // Header qword at SOF
  input  logic                   hdr_load_i,   // Capture descriptor
  output pcie_rx_pkg::tlp_kind_e tlp_kind_o,
  output pcie_rx_pkg::req_desc_t req_desc_o
);

  import pcie_rx_pkg::*;

  logic [6:0] fmt_type;
  logic [9:0] hdr_len;
  logic       len_ok;
  req_desc_t  desc_d;

  assign fmt_type = trn_rd_i[`HDR_FT_HI:`HDR_FT_LO];
  assign hdr_len  = trn_rd_i[`HDR_LEN_HI:`HDR_LEN_LO];
  assign len_ok   = (hdr_len == `HDR_LEN_ONE);   // 1DW payload only

  //------------------------------------------------------------
  // Classification
  //------------------------------------------------------------
  always_comb
  begin
    tlp_kind_o = TLP_NONE;
    if (len_ok)
    begin
      case (fmt_type)
        `FMT_TYPE_MWR32  : tlp_kind_o = TLP_MWR;
        `FMT_TYPE_MRD32  : tlp_kind_o = TLP_MRD;
        `FMT_TYPE_IOWR32 : tlp_kind_o = TLP_IOWR;
        `FMT_TYPE_IORD32 : tlp_kind_o = TLP_IORD;
        default          : tlp_kind_o = TLP_NONE;  // Cpl, 4DW, msg...
      endcase
    end
  end

  //------------------------------------------------------------
  // Descriptor fields straight from the header
  //------------------------------------------------------------
  always_comb
  begin
    desc_d.fmt_type = fmt_type;
    desc_d.tc       = trn_rd_i[`HDR_TC_HI:`HDR_TC_LO];
    desc_d.td       = trn_rd_i[`HDR_TD_BIT];
    desc_d.ep       = trn_rd_i[`HDR_EP_BIT];
    desc_d.attr     = trn_rd_i[`HDR_ATTR_HI:`HDR_ATTR_LO];
    desc_d.len      = hdr_len;
    desc_d.rid      = trn_rd_i[`HDR_RID_HI:`HDR_RID_LO];
    desc_d.tag      = trn_rd_i[`HDR_TAG_HI:`HDR_TAG_LO];
    desc_d.be       = trn_rd_i[`HDR_BE_HI:`HDR_BE_LO];   // Last/first DW BE
  end

  // Held until the next request that needs a completion
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_desc_o <= '0;
    end
    else if (hdr_load_i)
    begin
      req_desc_o <= desc_d;
    end
  end

endmodule

// File: verilog/rx_target_fsm.sv
/* Target packet FSM: destination ready, header and qword capture
   strobes, completion request handshake with the TX engine */
`timescale 1ns/10ps

module rx_target_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pcie_rx_pkg::trn_rx_t   trn_rx_i,
  input  pcie_rx_pkg::tlp_kind_e tlp_kind_i,       // From header decode
  input  logic                   compl_done_i,     // TX sent the Cpl/CplD
  output logic                   hdr_load_o,       // Capture descriptor
  output logic                   qw1_take_o,       // Capture addr/data
  output logic                   is_write_o,       // Packet carried data
  output logic                   trn_rdst_rdy_n_o,
  output logic                   req_compl_o
);

  import pcie_rx_pkg::*;

  rx_state_e state;
  logic      rdst_rdy_n;    // Registered ready, active low
  logic      req_compl;
  logic      is_write;      // MWr or IOWr
  logic      need_cpl;      // MRd, IOWr or IORd
  logic      beat_ok;       // Beat accepted this edge
  logic      sof_ok;
  logic      eof_ok;
  logic      kind_ok;       // Recognised request
  logic      kind_cpl;      // Recognised and needs completion

  //------------------------------------------------------------
  // Beat qualification
  //------------------------------------------------------------
  assign beat_ok = !trn_rx_i.src_rdy_n && !rdst_rdy_n && trn_rx_i.src_dsc_n;
  assign sof_ok  = beat_ok && !trn_rx_i.sof_n;
  assign eof_ok  = beat_ok && !trn_rx_i.eof_n;

  assign kind_ok  = (tlp_kind_i != TLP_NONE);
  assign kind_cpl = kind_ok && (tlp_kind_i != TLP_MWR);

  // Descriptor only for requests answered by a completion
  assign hdr_load_o = (state == ST_IDLE) && sof_ok && kind_cpl;
  assign qw1_take_o = (state == ST_QW1) && eof_ok;

  assign is_write_o       = is_write;
  assign trn_rdst_rdy_n_o = rdst_rdy_n;
  assign req_compl_o      = req_compl;

  //------------------------------------------------------------
  // State register and outputs
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      rdst_rdy_n <= 1'b0;             // Ready out of reset
      req_compl  <= 1'b0;
      is_write   <= 1'b0;
      need_cpl   <= 1'b0;
    end
    else
    begin
      case (state)

        ST_IDLE :
        begin
          if (sof_ok && kind_ok)
          begin
            is_write <= (tlp_kind_i == TLP_MWR) || (tlp_kind_i == TLP_IOWR);
            need_cpl <= kind_cpl;
            state    <= ST_QW1;
          end
        end

        ST_QW1 :
        begin
          if (!trn_rx_i.src_dsc_n)
          begin
            state <= ST_IDLE;         // Aborted by core, drop packet
          end
          else if (eof_ok)
          begin
            rdst_rdy_n <= 1'b1;       // Stall the bus for the tail
            if (!is_write)
              state <= ST_RD_WAIT1;
            else if (need_cpl)
            begin
              req_compl <= 1'b1;      // IOWr asks at once
              state     <= ST_CPL_WAIT;
            end
            else
              state <= ST_WR_END;
          end
        end

        // MWr: one stall cycle, then ready again
        ST_WR_END :
        begin
          rdst_rdy_n <= 1'b0;
          state      <= ST_IDLE;
        end

        // Read strobe is out, request the CplD after it
        ST_RD_WAIT1 :
        begin
          req_compl <= 1'b1;
          state     <= ST_CPL_WAIT;
        end

        ST_CPL_WAIT :
        begin
          if (compl_done_i)
          begin
            req_compl  <= 1'b0;
            rdst_rdy_n <= 1'b0;       // Release the bus
            state      <= ST_IDLE;
          end
        end

        default :
        begin
          req_compl  <= 1'b0;
          rdst_rdy_n <= 1'b0;
          state      <= ST_IDLE;
        end

      endcase
    end
  end

endmodule

// File: verilog/usr_reg_port.sv
/* User register port: address/data capture from the second qword,
   BAR-gated write and read strobes */
`timescale 1ns/10ps
`include "pcie_rx_params.svh"

module usr_reg_port (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [`TRN_DW-1:0]              trn_rd_i,
  input  logic [`TRN_BAR_W-1:0]           trn_rbar_hit_n_i,  // Active low hits
  input  logic                            qw1_take_i,        // EOF qword accepted
  input  logic                            is_write_i,
  output pcie_rx_pkg::usr_reg_t           usr_reg_o,
  output logic [`QW1_ADR_HI-`QW1_ADR_LO:0] req_addr_o        // ADDR[31:2]
);

  logic        bar_usr;     // BAR 0 or 1 hit
  logic [31:0] dat_q;
  logic [31:0] dat_swap;
  logic        wr_q;
  logic        rd_q;

  assign bar_usr = !trn_rbar_hit_n_i[`BAR_USR0] || !trn_rbar_hit_n_i[`BAR_USR1];

  //------------------------------------------------------------
  // Address and strobes
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_addr_o <= '0;
      wr_q       <= 1'b0;
      rd_q       <= 1'b0;
    end
    else
    begin
      if (qw1_take_i)
        req_addr_o <= trn_rd_i[`QW1_ADR_HI:`QW1_ADR_LO];
      // Single-cycle pulses, dropped on a BAR miss
      wr_q <= qw1_take_i && is_write_i && bar_usr;
      rd_q <= qw1_take_i && !is_write_i && bar_usr;
    end
  end

  // Payload DW, meaningful for writes only
  always_ff @(posedge clk)
  begin
    if (qw1_take_i)
      dat_q <= trn_rd_i[`QW1_DAT_HI:`QW1_DAT_LO];
  end

  // Link delivers byte 0 in the top lane
  assign dat_swap = {dat_q[7:0], dat_q[15:8], dat_q[23:16], dat_q[31:24]};

  //------------------------------------------------------------
  // Register port, DW-aligned byte address
  //------------------------------------------------------------
  assign usr_reg_o = '{
    adr : {req_addr_o[`USR_ADR_W-3:0], 2'b00},
    din : dat_swap,
    wr  : wr_q,
    rd  : rd_q
  };

endmodule
